// ==== common/amber_wb_params.svh ====
/*
 * System bus width and byte-select width
 * Address map of main memory and the MAC register block
 * Reset and fixed values of the MAC registers
 */
`ifndef AMBER_WB_PARAMS_SVH
`define AMBER_WB_PARAMS_SVH

// System data width, 128 by default and 32 also works
`define WB_DWIDTH       128
`define WB_SWIDTH       (`WB_DWIDTH / 8)

// Main memory depth in system-width words
`define MEM_WORDS       256

// Main memory sits at the bottom of the map and covers exactly its own size
`define MEM_BASE        32'h0000_0000
`define MEM_MASK        (~(32'(`MEM_WORDS * `WB_SWIDTH) - 32'd1))

// MAC register block, a 256 byte window
`define ETH_REG_BASE    32'h2000_0000
`define ETH_REG_MASK    32'hFFFF_FF00

// MODER comes out of reset with pad and CRC enabled, like the real MAC
`define ETH_MODER_RESET 32'h0000_A000
`define ETH_ID_VALUE    32'hE7AC_0001

`endif

// ==== common/system_functions.svh ====
/*
 * Byte-order helpers for the endian switch
 */
`ifndef SYSTEM_FUNCTIONS_SVH
`define SYSTEM_FUNCTIONS_SVH

// Reverse the four bytes of a 32-bit word
function automatic logic [31:0] endian_x32(input logic [31:0] data);
    return {data[7:0], data[15:8], data[23:16], data[31:24]};
endfunction

// Reverse four byte selects so they follow their swapped bytes
function automatic logic [3:0] endian_x4(input logic [3:0] sel);
    return {sel[0], sel[1], sel[2], sel[3]};
endfunction

`endif

// ==== common/amber_wb_pkg.sv ====
/*
 * Wishbone request and response structs for the 32-bit MAC side
 * and the system-width side, plus arbiter state and target enums
 */
`include "amber_wb_params.svh"
`default_nettype none

package amber_wb_pkg;

    // ========================================
    // 32-bit bus on the MAC side
    // ========================================

    typedef struct packed {
        logic [31:0] adr;
        logic [3:0]  sel;
        logic        we;
        logic [31:0] wdat;
        logic        cyc;
        logic        stb;
    } wb32_req_t;

    typedef struct packed {
        logic [31:0] rdat;
        logic        ack;
        logic        err;
    } wb32_rsp_t;

    // ========================================
    // System-width bus
    // ========================================

    // The address stays 32 bits whatever the data width
    typedef struct packed {
        logic [31:0]            adr;
        logic [`WB_SWIDTH-1:0]  sel;
        logic                   we;
        logic [`WB_DWIDTH-1:0]  wdat;
        logic                   cyc;
        logic                   stb;
    } wbs_req_t;

    typedef struct packed {
        logic [`WB_DWIDTH-1:0]  rdat;
        logic                   ack;
        logic                   err;
    } wbs_rsp_t;

    // Which master owns the bus
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ETH,
        ARB_CPU
    } arb_state_e;

    // Decoded slave for the granted address
    typedef enum logic [1:0] {
        TGT_MEM,
        TGT_ETH,
        TGT_NONE
    } wb_target_e;

endpackage

`default_nettype wire

// ==== ethmac/ethmac_wb.sv ====
/*
 * Bus width and endian switch between the 32-bit little-endian MAC
 * and the big-endian system bus, for both master and slave paths
 */
`include "amber_wb_params.svh"
`default_nettype none

module ethmac_wb (
    // MAC DMA master, 32-bit little-endian
    input  wire amber_wb_pkg::wb32_req_t i_m_req,
    output amber_wb_pkg::wb32_rsp_t      o_m_rsp,

    // Master request towards the arbiter at system width
    output amber_wb_pkg::wbs_req_t       o_m_req,
    input  wire amber_wb_pkg::wbs_rsp_t  i_m_rsp,

    // Slave request from the arbiter at system width
    input  wire amber_wb_pkg::wbs_req_t  i_s_req,
    output amber_wb_pkg::wbs_rsp_t       o_s_rsp,

    // Slave request to the MAC register block
    output amber_wb_pkg::wb32_req_t      o_s_req,
    input  wire amber_wb_pkg::wb32_rsp_t i_s_rsp
);

    `include "system_functions.svh"

    // Number of 32-bit lanes on the system bus, 4 or 1
    localparam int LANES = `WB_DWIDTH / 32;

    // Lane picked by address bits 3 to 2, always lane 0 on a 32-bit bus
    logic [1:0] m_lane;
    logic [1:0] s_lane;

    assign m_lane = (LANES > 1) ? i_m_req.adr[3:2] : 2'd0;
    assign s_lane = (LANES > 1) ? i_s_req.adr[3:2] : 2'd0;

    // ========================================
    // Master path, with endian conversion
    // ========================================

    always_comb
    begin
        o_m_req.adr = i_m_req.adr;
        o_m_req.we  = i_m_req.we;
        o_m_req.cyc = i_m_req.cyc;
        o_m_req.stb = i_m_req.stb;

        // Unused lanes carry zero data and no selects
        o_m_req.sel  = '0;
        o_m_req.wdat = '0;
        o_m_req.sel[m_lane*4 +: 4]   = endian_x4(i_m_req.sel);
        o_m_req.wdat[m_lane*32 +: 32] = endian_x32(i_m_req.wdat);

        // Read data comes back from the same lane and is swapped again
        o_m_rsp.rdat = endian_x32(i_m_rsp.rdat[m_lane*32 +: 32]);
        o_m_rsp.ack  = i_m_rsp.ack;
        o_m_rsp.err  = i_m_rsp.err;
    end

    // ========================================
    // Slave path, lane select only
    // ========================================

    always_comb
    begin
        o_s_req.adr  = i_s_req.adr;
        o_s_req.we   = i_s_req.we;
        o_s_req.cyc  = i_s_req.cyc;
        o_s_req.stb  = i_s_req.stb;
        o_s_req.sel  = i_s_req.sel[s_lane*4 +: 4];
        o_s_req.wdat = i_s_req.wdat[s_lane*32 +: 32];

        // Register data is placed back in the lane it was addressed on
        o_s_rsp.rdat = '0;
        o_s_rsp.rdat[s_lane*32 +: 32] = i_s_rsp.rdat;
        o_s_rsp.ack  = i_s_rsp.ack;
        o_s_rsp.err  = i_s_rsp.err;
    end

endmodule

`default_nettype wire

// ==== ethmac/ethmac_regs.sv ====
/*
 * MAC register block, a 32-bit Wishbone classic slave with
 * MODER, two address registers, a scratch register and an ID
 */
`include "amber_wb_params.svh"
`default_nettype none

module ethmac_regs (
    input  wire logic                    i_clk,
    input  wire logic                    i_reset,
    input  wire amber_wb_pkg::wb32_req_t i_req,
    output amber_wb_pkg::wb32_rsp_t      o_rsp
);

    // Word offsets inside the register window
    localparam logic [5:0] OFS_MODER     = 6'd0;
    localparam logic [5:0] OFS_MAC_ADDR0 = 6'd1;
    localparam logic [5:0] OFS_MAC_ADDR1 = 6'd2;
    localparam logic [5:0] OFS_SCRATCH   = 6'd3;
    localparam logic [5:0] OFS_ID        = 6'd4;

    logic [31:0] moder;
    logic [31:0] mac_addr0;
    logic [15:0] mac_addr1;
    logic [31:0] scratch;
    logic [31:0] addr1_new;
    logic [31:0] rd_mux;
    logic [31:0] rdat_q;
    logic [5:0]  word;
    logic        access;
    logic        ack_q;

    // Replace only the bytes whose select is set
    function automatic logic [31:0] merge32(input logic [31:0] old_val,
                                            input logic [31:0] wdat,
                                            input logic [3:0]  sel);
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++)
        begin
            if (sel[b])
            begin
                res[b*8 +: 8] = wdat[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign word      = i_req.adr[7:2];
    assign addr1_new = merge32({16'd0, mac_addr1}, i_req.wdat, i_req.sel);

    // A new strobe is taken only while ack is low, one ack per strobe
    assign access = i_req.cyc & i_req.stb & ~ack_q;

    // ========================================
    // Register writes and ack
    // ========================================

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            ack_q     <= 1'b0;
            moder     <= `ETH_MODER_RESET;
            mac_addr0 <= '0;
            mac_addr1 <= '0;
            scratch   <= '0;
        end
        else
        begin
            ack_q <= access;
            if (access && i_req.we)
            begin
                // ID and unknown offsets drop the write
                case (word)
                    OFS_MODER:     moder     <= merge32(moder, i_req.wdat, i_req.sel);
                    OFS_MAC_ADDR0: mac_addr0 <= merge32(mac_addr0, i_req.wdat, i_req.sel);
                    OFS_MAC_ADDR1: mac_addr1 <= addr1_new[15:0];
                    OFS_SCRATCH:   scratch   <= merge32(scratch, i_req.wdat, i_req.sel);
                    default:       ;
                endcase
            end
        end
    end

    // ========================================
    // Read path
    // ========================================

    always_comb
    begin
        case (word)
            OFS_MODER:     rd_mux = moder;
            OFS_MAC_ADDR0: rd_mux = mac_addr0;
            OFS_MAC_ADDR1: rd_mux = {16'd0, mac_addr1};
            OFS_SCRATCH:   rd_mux = scratch;
            OFS_ID:        rd_mux = `ETH_ID_VALUE;
            default:       rd_mux = '0;
        endcase
    end

    // Read data is captured with the strobe so it is valid with ack
    always_ff @(posedge i_clk)
    begin
        if (access)
        begin
            rdat_q <= rd_mux;
        end
    end

    always_comb
    begin
        o_rsp.rdat = rdat_q;
        o_rsp.ack  = ack_q;
        o_rsp.err  = 1'b0;
    end

endmodule

`default_nettype wire

// ==== logic/wb_arbiter.sv ====
/*
 * Two-master Wishbone arbiter with MAC priority, address decode
 * to memory, MAC registers or an internal error response
 */
`include "amber_wb_params.svh"
`default_nettype none

module wb_arbiter (
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    input  wire amber_wb_pkg::wbs_req_t i_eth_req,
    output amber_wb_pkg::wbs_rsp_t      o_eth_rsp,
    input  wire amber_wb_pkg::wbs_req_t i_cpu_req,
    output amber_wb_pkg::wbs_rsp_t      o_cpu_rsp,
    output amber_wb_pkg::wbs_req_t      o_mem_req,
    input  wire amber_wb_pkg::wbs_rsp_t i_mem_rsp,
    output amber_wb_pkg::wbs_req_t      o_ethreg_req,
    input  wire amber_wb_pkg::wbs_rsp_t i_ethreg_rsp
);

    import amber_wb_pkg::*;

    arb_state_e state;
    arb_state_e state_nxt;
    wb_target_e target;
    wbs_req_t   gnt_req;
    wbs_rsp_t   gnt_rsp;
    logic       err_q;

    // ========================================
    // Grant state machine
    // ========================================

    always_comb
    begin
        state_nxt = state;
        case (state)
            ARB_IDLE:
            begin
                // MAC wins when both ask in the same cycle
                if (i_eth_req.cyc && i_eth_req.stb)
                begin
                    state_nxt = ARB_ETH;
                end
                else if (i_cpu_req.cyc && i_cpu_req.stb)
                begin
                    state_nxt = ARB_CPU;
                end
            end
            // The grant lasts until the owner closes its cycle
            ARB_ETH:  if (!i_eth_req.cyc) state_nxt = ARB_IDLE;
            ARB_CPU:  if (!i_cpu_req.cyc) state_nxt = ARB_IDLE;
            default:  state_nxt = ARB_IDLE;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state <= ARB_IDLE;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    // Only the granted master reaches the slaves, nothing while idle
    always_comb
    begin
        case (state)
            ARB_ETH: gnt_req = i_eth_req;
            ARB_CPU: gnt_req = i_cpu_req;
            default: gnt_req = '0;
        endcase
    end

    // ========================================
    // Address decode and routing
    // ========================================

    always_comb
    begin
        if ((gnt_req.adr & `MEM_MASK) == `MEM_BASE)
        begin
            target = TGT_MEM;
        end
        else if ((gnt_req.adr & `ETH_REG_MASK) == `ETH_REG_BASE)
        begin
            target = TGT_ETH;
        end
        else
        begin
            target = TGT_NONE;
        end
    end

    // Every slave sees the address and data, only the target sees the strobe
    always_comb
    begin
        o_mem_req        = gnt_req;
        o_mem_req.cyc    = gnt_req.cyc & (target == TGT_MEM);
        o_mem_req.stb    = gnt_req.stb & (target == TGT_MEM);
        o_ethreg_req     = gnt_req;
        o_ethreg_req.cyc = gnt_req.cyc & (target == TGT_ETH);
        o_ethreg_req.stb = gnt_req.stb & (target == TGT_ETH);
    end

    // Unmapped accesses get a one-cycle err, timed like a slave ack
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            err_q <= 1'b0;
        end
        else
        begin
            err_q <= gnt_req.cyc & gnt_req.stb & (target == TGT_NONE) & ~err_q;
        end
    end

    always_comb
    begin
        case (target)
            TGT_MEM: gnt_rsp = i_mem_rsp;
            TGT_ETH: gnt_rsp = i_ethreg_rsp;
            default: gnt_rsp = '{rdat: '0, ack: 1'b0, err: err_q};
        endcase
    end

    // A master without the grant sees no response, which stalls it
    assign o_eth_rsp = (state == ARB_ETH) ? gnt_rsp : '0;
    assign o_cpu_rsp = (state == ARB_CPU) ? gnt_rsp : '0;

endmodule

`default_nettype wire

// ==== logic/main_mem.sv ====
/*
 * Main memory, system-width words with byte selects,
 * a Wishbone classic slave with a registered ack
 */
`include "amber_wb_params.svh"
`default_nettype none

module main_mem (
    input  wire logic                   i_clk,
    input  wire logic                   i_reset,
    input  wire amber_wb_pkg::wbs_req_t i_req,
    output amber_wb_pkg::wbs_rsp_t      o_rsp
);

    // The word index sits just above the byte offset
    localparam int ADR_LSB = $clog2(`WB_SWIDTH);
    localparam int IDX_W   = $clog2(`MEM_WORDS);

    logic [`WB_DWIDTH-1:0] mem [`MEM_WORDS];
    logic [`WB_DWIDTH-1:0] rdat_q;
    logic [IDX_W-1:0]      idx;
    logic                  access;
    logic                  ack_q;

    assign idx    = i_req.adr[ADR_LSB +: IDX_W];
    assign access = i_req.cyc & i_req.stb & ~ack_q;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            ack_q <= 1'b0;
        end
        else
        begin
            ack_q <= access;
        end
    end

    // Storage and read data
    always_ff @(posedge i_clk)
    begin
        if (access)
        begin
            if (i_req.we)
            begin
                for (int b = 0; b < `WB_SWIDTH; b++)
                begin
                    if (i_req.sel[b])
                    begin
                        mem[idx][b*8 +: 8] <= i_req.wdat[b*8 +: 8];
                    end
                end
            end
            rdat_q <= mem[idx];
        end
    end

    always_comb
    begin
        o_rsp.rdat = rdat_q;
        o_rsp.ack  = ack_q;
        o_rsp.err  = 1'b0;
    end

endmodule

`default_nettype wire

// ==== logic/amber_eth_sys.sv ====
/*
 * Top level joining the CPU and MAC masters, the endian switch,
 * the arbiter, main memory and the MAC register block
 */
`default_nettype none

module amber_eth_sys (
    input  wire logic                    i_clk,
    input  wire logic                    i_reset,
    input  wire amber_wb_pkg::wbs_req_t  i_cpu_req,
    output amber_wb_pkg::wbs_rsp_t       o_cpu_rsp,
    input  wire amber_wb_pkg::wb32_req_t i_eth_req,
    output amber_wb_pkg::wb32_rsp_t      o_eth_rsp
);

    import amber_wb_pkg::*;

    // MAC master after width conversion
    wbs_req_t  eth_sys_req;
    wbs_rsp_t  eth_sys_rsp;

    // Arbiter to slaves
    wbs_req_t  mem_req;
    wbs_rsp_t  mem_rsp;
    wbs_req_t  ethreg_req;
    wbs_rsp_t  ethreg_rsp;

    // Switch to the 32-bit register block
    wb32_req_t regs_req;
    wb32_rsp_t regs_rsp;

    ethmac_wb u_ethmac_wb (
        .i_m_req (i_eth_req),
        .o_m_rsp (o_eth_rsp),
        .o_m_req (eth_sys_req),
        .i_m_rsp (eth_sys_rsp),
        .i_s_req (ethreg_req),
        .o_s_rsp (ethreg_rsp),
        .o_s_req (regs_req),
        .i_s_rsp (regs_rsp)
    );

    wb_arbiter u_wb_arbiter (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_eth_req    (eth_sys_req),
        .o_eth_rsp    (eth_sys_rsp),
        .i_cpu_req    (i_cpu_req),
        .o_cpu_rsp    (o_cpu_rsp),
        .o_mem_req    (mem_req),
        .i_mem_rsp    (mem_rsp),
        .o_ethreg_req (ethreg_req),
        .i_ethreg_rsp (ethreg_rsp)
    );

    main_mem u_main_mem (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_req   (mem_req),
        .o_rsp   (mem_rsp)
    );

    ethmac_regs u_ethmac_regs (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_req   (regs_req),
        .o_rsp   (regs_rsp)
    );

endmodule

`default_nettype wire

// ==== test/amber_eth_sys_assert.sv ====
/*
 * Concurrent checks on the arbiter grant and response rules,
 * bound into the wb_arbiter module
 */
`default_nettype none

module amber_eth_sys_assert (
    input wire logic                     i_clk,
    input wire logic                     i_reset,
    input wire amber_wb_pkg::arb_state_e i_state,
    input wire amber_wb_pkg::wbs_rsp_t   i_eth_rsp,
    input wire amber_wb_pkg::wbs_rsp_t   i_cpu_rsp
);

    import amber_wb_pkg::*;

    // ========================================
    // Grant rules
    // ========================================

    // An ack answers a strobe issued under the same grant one cycle earlier,
    // so an ack meant for the other master never leaks across a grant change
    eth_ack_granted: assert property (@(posedge i_clk) disable iff (i_reset)
        i_eth_rsp.ack |-> $past(i_state) == ARB_ETH)
        else $error("MAC port acked for a strobe it did not own");

    cpu_ack_granted: assert property (@(posedge i_clk) disable iff (i_reset)
        i_cpu_rsp.ack |-> $past(i_state) == ARB_CPU)
        else $error("CPU port acked for a strobe it did not own");

    // ========================================
    // Response rules
    // ========================================

    eth_ack_err_excl: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_eth_rsp.ack && i_eth_rsp.err))
        else $error("MAC port saw ack and err together");

    cpu_ack_err_excl: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_cpu_rsp.ack && i_cpu_rsp.err))
        else $error("CPU port saw ack and err together");

    // One response per strobe, so neither may stay high a second cycle
    eth_rsp_single: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_eth_rsp.ack || i_eth_rsp.err) |=> !(i_eth_rsp.ack || i_eth_rsp.err))
        else $error("MAC port response longer than one cycle");

    cpu_rsp_single: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_cpu_rsp.ack || i_cpu_rsp.err) |=> !(i_cpu_rsp.ack || i_cpu_rsp.err))
        else $error("CPU port response longer than one cycle");

endmodule

bind wb_arbiter amber_eth_sys_assert u_arb_assert (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_state   (state),
    .i_eth_rsp (o_eth_rsp),
    .i_cpu_rsp (o_cpu_rsp)
);

`default_nettype wire

// ==== test/tb_amber_eth_sys.sv ====
/*
 * Directed testbench for the Wishbone fabric with clock, reset,
 * CPU and MAC bus tasks, a value check and the tests
 */
`include "amber_wb_params.svh"
`default_nettype none

module tb_amber_eth_sys;

    import amber_wb_pkg::*;

    localparam int          DW      = `WB_DWIDTH;
    localparam int          SW      = `WB_SWIDTH;
    localparam int          TIMEOUT = 50;
    // MAC word in memory whose address bits 3 to 2 pick lane 2
    localparam logic [31:0] MAC_ADR = 32'h0000_0108;
    localparam int          MAC_IDX = int'(MAC_ADR / SW);
    // Outside both the memory and the register window
    localparam logic [31:0] BAD_ADR = 32'h4000_0000;

    logic      clk;
    logic      reset;
    wbs_req_t  cpu_req;
    wbs_rsp_t  cpu_rsp;
    wb32_req_t eth_req;
    wb32_rsp_t eth_rsp;

    // Reference copy of main memory, one entry per system word
    logic [DW-1:0] mem_model [`MEM_WORDS];
    time           cpu_done_t;
    time           eth_done_t;

    amber_eth_sys dut0 (
        .i_clk     (clk),
        .i_reset   (reset),
        .i_cpu_req (cpu_req),
        .o_cpu_rsp (cpu_rsp),
        .i_eth_req (eth_req),
        .o_eth_rsp (eth_rsp)
    );

    always #10 clk = ~clk;

    // ========================================
    // Reporting and reference models
    // ========================================

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check(input logic [DW-1:0] got, input logic [DW-1:0] exp,
                         input string what);
        if (got !== exp)
        begin
            stop_run($sformatf("FAIL at time %0t: %s, got %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    function automatic logic [DW-1:0] rand_word();
        logic [DW-1:0] w;
        for (int i = 0; i < DW / 32; i++)
        begin
            w[i*32 +: 32] = $urandom();
        end
        return w;
    endfunction

    function automatic logic [31:0] word_adr(input int idx);
        return 32'(idx * SW);
    endfunction

    // The 32-bit lane is chosen by address bits 3 to 2 on a wide bus
    function automatic int lane_of(input logic [31:0] adr);
        return (DW > 32) ? int'(adr[3:2]) : 0;
    endfunction

    function automatic logic [DW-1:0] in_lane(input logic [31:0] v, input logic [31:0] adr);
        logic [DW-1:0] res;
        res = '0;
        res[lane_of(adr)*32 +: 32] = v;
        return res;
    endfunction

    function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_val,
                                                  input logic [DW-1:0] new_val,
                                                  input logic [SW-1:0] sel);
        logic [DW-1:0] res;
        res = old_val;
        for (int b = 0; b < SW; b++)
        begin
            if (sel[b])
            begin
                res[b*8 +: 8] = new_val[b*8 +: 8];
            end
        end
        return res;
    endfunction

    // Little-endian MAC byte j lands on big-endian byte 3-j of its lane
    function automatic logic [DW-1:0] mac_write_model(input logic [DW-1:0] old_val,
                                                      input logic [31:0] adr,
                                                      input logic [31:0] d,
                                                      input logic [3:0]  sel);
        logic [DW-1:0] res;
        int            lane;
        res  = old_val;
        lane = lane_of(adr);
        for (int j = 0; j < 4; j++)
        begin
            if (sel[j])
            begin
                res[(lane*4 + 3 - j)*8 +: 8] = d[j*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic logic [31:0] mac_read_model(input logic [DW-1:0] word,
                                                   input logic [31:0] adr);
        logic [31:0] res;
        int          lane;
        lane = lane_of(adr);
        for (int j = 0; j < 4; j++)
        begin
            res[j*8 +: 8] = word[(lane*4 + 3 - j)*8 +: 8];
        end
        return res;
    endfunction

    // ========================================
    // Bus tasks for both masters
    // ========================================

    task automatic cpu_access(input logic we, input logic [31:0] adr,
                              input logic [SW-1:0] sel, input logic [DW-1:0] wdat,
                              output logic [DW-1:0] rdat, output logic ack,
                              output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        cpu_req <= '{adr: adr, sel: sel, we: we, wdat: wdat, cyc: 1'b1, stb: 1'b1};
        // Responses are sampled on the falling edge, away from the drive edge
        do
        begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
            begin
                stop_run("Timeout: the CPU port got neither ack nor err");
            end
        end
        while (!(cpu_rsp.ack || cpu_rsp.err));
        rdat       = cpu_rsp.rdat;
        ack        = cpu_rsp.ack;
        err        = cpu_rsp.err;
        cpu_done_t = $time;
        @(posedge clk);
        cpu_req <= '0;
    endtask

    task automatic eth_access(input logic we, input logic [31:0] adr,
                              input logic [3:0] sel, input logic [31:0] wdat,
                              output logic [31:0] rdat, output logic ack,
                              output logic err);
        int waited;
        waited = 0;
        @(posedge clk);
        eth_req <= '{adr: adr, sel: sel, we: we, wdat: wdat, cyc: 1'b1, stb: 1'b1};
        do
        begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT)
            begin
                stop_run("Timeout: the MAC port got neither ack nor err");
            end
        end
        while (!(eth_rsp.ack || eth_rsp.err));
        rdat       = eth_rsp.rdat;
        ack        = eth_rsp.ack;
        err        = eth_rsp.err;
        eth_done_t = $time;
        @(posedge clk);
        eth_req <= '0;
    endtask

    task automatic cpu_write(input logic [31:0] adr, input logic [SW-1:0] sel,
                             input logic [DW-1:0] wdat);
        logic [DW-1:0] rdat;
        logic          ack;
        logic          err;
        cpu_access(1'b1, adr, sel, wdat, rdat, ack, err);
        check(DW'({ack, err}), DW'(2'b10), "CPU write response");
    endtask

    task automatic cpu_read(input logic [31:0] adr, input logic [DW-1:0] exp,
                            input string what);
        logic [DW-1:0] rdat;
        logic          ack;
        logic          err;
        cpu_access(1'b0, adr, '0, '0, rdat, ack, err);
        check(DW'({ack, err}), DW'(2'b10), "CPU read response");
        check(rdat, exp, what);
    endtask

    // ========================================
    // Tests
    // ========================================

    task automatic test_reset();
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            check(DW'({cpu_rsp.ack, cpu_rsp.err, eth_rsp.ack, eth_rsp.err}), '0,
                  "responses idle after reset");
        end
    endtask

    task automatic test_cpu_mem();
        logic [DW-1:0] d;
        logic [SW-1:0] sel;
        // Full words first, so the partial writes merge into known data
        for (int i = 0; i < 6; i++)
        begin
            d = rand_word();
            cpu_write(word_adr(i), '1, d);
            mem_model[i] = d;
        end
        for (int i = 0; i < 6; i++)
        begin
            d   = rand_word();
            sel = SW'($urandom());
            cpu_write(word_adr(i), sel, d);
            mem_model[i] = merge_bytes(mem_model[i], d, sel);
        end
        for (int i = 0; i < 6; i++)
        begin
            cpu_read(word_adr(i), mem_model[i], "CPU memory readback");
        end
    endtask

    task automatic test_mac_to_cpu();
        logic [31:0] d;
        logic [31:0] rdat;
        logic        ack;
        logic        err;
        mem_model[MAC_IDX] = rand_word();
        cpu_write(word_adr(MAC_IDX), '1, mem_model[MAC_IDX]);
        d = $urandom();
        eth_access(1'b1, MAC_ADR, 4'b0011, d, rdat, ack, err);
        check(DW'({ack, err}), DW'(2'b10), "MAC write response");
        mem_model[MAC_IDX] = mac_write_model(mem_model[MAC_IDX], MAC_ADR, d, 4'b0011);
        cpu_read(word_adr(MAC_IDX), mem_model[MAC_IDX], "CPU view of MAC write");
    endtask

    task automatic test_mac_regs();
        logic [DW-1:0] w;
        logic [DW-1:0] exp_w;
        logic [SW-1:0] sel;
        logic [31:0]   adr;
        logic [31:0]   v;
        logic [31:0]   exp;
        int            lane;
        // MODER, MAC_ADDR0, MAC_ADDR1 and SCRATCH, each on its own lane
        for (int r = 0; r < 4; r++)
        begin
            adr  = `ETH_REG_BASE + 32'(4 * r);
            lane = lane_of(adr);
            v    = $urandom();
            w    = rand_word();
            w[lane*32 +: 32] = v;
            cpu_write(adr, '1, w);
            exp = (r == 2) ? {16'd0, v[15:0]} : v;
            cpu_read(adr, in_lane(exp, adr), "MAC register readback");
        end
        // SCRATCH keeps the bytes whose select is clear
        adr   = `ETH_REG_BASE + 32'hC;
        lane  = lane_of(adr);
        w     = '0;
        w[lane*32 +: 32] = $urandom();
        sel   = SW'(4'b0101) << (lane * 4);
        exp_w = merge_bytes(in_lane(exp, adr), w, sel);
        cpu_write(adr, sel, w);
        cpu_read(adr, exp_w, "SCRATCH partial write");
        adr = `ETH_REG_BASE + 32'h10;
        cpu_write(adr, '1, rand_word());
        cpu_read(adr, in_lane(`ETH_ID_VALUE, adr), "ID register after write");
    endtask

    task automatic test_priority();
        logic [DW-1:0] c_rdat;
        logic          c_ack;
        logic          c_err;
        logic [31:0]   e_rdat;
        logic          e_ack;
        logic          e_err;
        fork
            cpu_access(1'b0, word_adr(1), '0, '0, c_rdat, c_ack, c_err);
            eth_access(1'b0, MAC_ADR, 4'hF, '0, e_rdat, e_ack, e_err);
        join
        check(DW'({c_ack, c_err, e_ack, e_err}), DW'(4'b1010), "responses under contention");
        check(DW'(eth_done_t < cpu_done_t), DW'(1), "MAC ack ahead of CPU ack");
        check(c_rdat, mem_model[1], "CPU data under contention");
        check(DW'(e_rdat), DW'(mac_read_model(mem_model[MAC_IDX], MAC_ADR)),
              "MAC data under contention");
    endtask

    task automatic test_unmapped();
        logic [DW-1:0] c_rdat;
        logic          c_ack;
        logic          c_err;
        logic [31:0]   e_rdat;
        logic          e_ack;
        logic          e_err;
        cpu_access(1'b0, BAD_ADR, '0, '0, c_rdat, c_ack, c_err);
        check(DW'({c_ack, c_err}), DW'(2'b01), "CPU unmapped access");
        eth_access(1'b1, BAD_ADR, 4'hF, $urandom(), e_rdat, e_ack, e_err);
        check(DW'({e_ack, e_err}), DW'(2'b01), "MAC unmapped access");
        cpu_read(word_adr(2), mem_model[2], "CPU read after an error");
    endtask

    initial
    begin
        void'($urandom(32'h3759));
        clk     = 1'b0;
        reset   = 1'b1;
        cpu_req = '0;
        eth_req = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        test_reset();
        test_cpu_mem();
        test_mac_to_cpu();
        test_mac_regs();
        test_priority();
        test_unmapped();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== amber_eth_sys.f ====
+incdir+common
common/amber_wb_pkg.sv
ethmac/ethmac_wb.sv
ethmac/ethmac_regs.sv
logic/wb_arbiter.sv
logic/main_mem.sv
logic/amber_eth_sys.sv
test/amber_eth_sys_assert.sv
test/tb_amber_eth_sys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
    --top-module tb_amber_eth_sys \
    -Mdir obj_dir \
    -f amber_eth_sys.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtb_amber_eth_sys
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit "$status"
fi

echo "Simulation finished with status 0"
exit 0
